/* mdio_defs.svh */
`ifndef MDIO_DEFS_SVH
`define MDIO_DEFS_SVH

////////////////////
// MDC generation
////////////////////

// System clocks per MDC period, kept even so MDC has a 50% duty cycle.
`define MDIO_CLK_DIV 8

////////////////////
// Frame layout
////////////////////

`define MDIO_FRAME_BITS 64 // Preamble plus clause-22 frame.
`define MDIO_RD_SAMPLE 46  // Bits driven before a read turns the bus around.

////////////////////
// Link poll
////////////////////

`define MDIO_POLL_INTERVAL 2000
`define MDIO_POLL_PHYAD 5'd1
`define MDIO_POLL_REGAD 5'd1 // Basic status register.
`define MDIO_LINK_BIT 2      // Link status bit of the basic status register.

`endif

/* mdio_frame_pkg.sv */
`default_nettype none

package mdio_frame_pkg;

  ////////////////////
  // Opcodes
  ////////////////////

  // Only the two clause-22 opcodes are supported.
  typedef enum logic [1:0] {
    MDIO_OP_WRITE = 2'b01,
    MDIO_OP_READ  = 2'b10
  } mdio_op_e;

  ////////////////////
  // Frame word
  ////////////////////

  // Fields in the order they appear on the wire, first bit at the MSB.
  typedef struct packed {
    logic [1:0]  start; // Always 01 for clause 22.
    mdio_op_e    op;
    logic [4:0]  phyad;
    logic [4:0]  regad;
    logic [1:0]  ta;    // Driven 10 on writes, released on reads.
    logic [15:0] data;
  } mdio_frame_t;

endpackage

`default_nettype wire

/* mdio_mgmt_pkg.sv */
`default_nettype none

package mdio_mgmt_pkg;

  // One-hot shifter states.
  typedef enum logic [4:0] {
    ST_IDLE    = 5'b00001,
    ST_REQ_BUS = 5'b00010,
    ST_LOAD    = 5'b00100,
    ST_SHIFT   = 5'b01000,
    ST_DONE    = 5'b10000
  } shift_state_e;

  // Pin levels one requester presents to the arbiter.
  typedef struct packed {
    logic mdc;
    logic mdo;
    logic oe;
  } mdio_pins_t;

  // Result of the background link poll.
  typedef struct packed {
    logic        link_up;
    logic [15:0] status;  // Last status register value read.
    logic [7:0]  count;   // Completed polls, wraps.
  } poll_status_t;

endpackage

`default_nettype wire

/* mdio_shifter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mdio_defs.svh"

module mdio_shifter (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          en_i,
  input  wire mdio_frame_pkg::mdio_frame_t frame_i,
  input  wire                          mdio_i,
  output mdio_mgmt_pkg::mdio_pins_t    pins_o,
  output logic [15:0]                  rdata_o,
  output logic                         rd_done_o,
  output logic                         wr_done_o,
  output logic                         bus_req_o,
  input  wire                          bus_gnt_i
);

  localparam int DIV = `MDIO_CLK_DIV;
  localparam int DIV_W = $clog2(DIV);
  localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(DIV / 2 - 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DIV - 1);
  localparam int FRAME_W = $bits(mdio_frame_pkg::mdio_frame_t);
  localparam int PRE_BITS = `MDIO_FRAME_BITS - FRAME_W;
  localparam int CNT_W = $clog2(`MDIO_FRAME_BITS + 1);
  localparam logic [CNT_W-1:0] BITS_LAST = CNT_W'(`MDIO_FRAME_BITS);
  localparam logic [CNT_W-1:0] RD_AT = CNT_W'(`MDIO_RD_SAMPLE);

  mdio_mgmt_pkg::shift_state_e state_q, state_d;
  mdio_frame_pkg::mdio_frame_t frame_q;

  logic [DIV_W-1:0]            div_cnt;
  logic                        mdc_q;
  logic                        tick;
  logic [CNT_W-1:0]            bit_cnt;
  logic [`MDIO_FRAME_BITS-1:0] sreg;
  logic [15:0]                 cap;
  logic                        mdo_q;
  logic                        oe_q;
  logic                        rd_op;

  ////////////////////
  // MDC divider
  ////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_cnt <= '0;
      mdc_q   <= 1'b0;
    end else if (div_cnt == DIV_LAST) begin
      div_cnt <= '0;
      mdc_q   <= 1'b0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      if (div_cnt == DIV_HALF) begin
        mdc_q <= 1'b1; // High for the second half of the period.
      end
    end
  end

  assign tick  = (div_cnt == '0); // Bits change while MDC is low.
  assign rd_op = (frame_q.op == mdio_frame_pkg::MDIO_OP_READ);

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      mdio_mgmt_pkg::ST_IDLE: begin
        if (en_i) begin
          state_d = mdio_mgmt_pkg::ST_REQ_BUS;
        end
      end
      mdio_mgmt_pkg::ST_REQ_BUS: begin
        if (bus_gnt_i) begin
          state_d = mdio_mgmt_pkg::ST_LOAD;
        end
      end
      mdio_mgmt_pkg::ST_LOAD:  state_d = mdio_mgmt_pkg::ST_SHIFT;
      mdio_mgmt_pkg::ST_SHIFT: begin
        if (tick && bit_cnt == BITS_LAST) begin
          state_d = mdio_mgmt_pkg::ST_DONE;
        end
      end
      default: state_d = mdio_mgmt_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= mdio_mgmt_pkg::ST_IDLE;
      bit_cnt   <= '0;
      bus_req_o <= 1'b0;
      rd_done_o <= 1'b1;
      wr_done_o <= 1'b1;
      mdo_q     <= 1'b0;
      oe_q      <= 1'b0;
      rdata_o   <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        mdio_mgmt_pkg::ST_IDLE: begin
          if (en_i) begin
            bus_req_o <= 1'b1;
          end
        end
        mdio_mgmt_pkg::ST_LOAD: begin
          bit_cnt <= '0;
          if (rd_op) begin
            rd_done_o <= 1'b0;
          end else begin
            wr_done_o <= 1'b0;
          end
        end
        mdio_mgmt_pkg::ST_SHIFT: begin
          if (tick && bit_cnt != BITS_LAST) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (rd_op && bit_cnt >= RD_AT) begin
              oe_q <= 1'b0; // Turnaround and data come from the PHY.
            end else begin
              oe_q  <= 1'b1;
              mdo_q <= sreg[`MDIO_FRAME_BITS-1];
            end
          end
        end
        mdio_mgmt_pkg::ST_DONE: begin
          bus_req_o <= 1'b0;
          oe_q      <= 1'b0;
          if (rd_op) begin
            rdata_o   <= cap;
            rd_done_o <= 1'b1;
          end else begin
            wr_done_o <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  ////////////////////
  // Shift data path
  ////////////////////

  always_ff @(posedge clk) begin
    if (state_q == mdio_mgmt_pkg::ST_IDLE && en_i) begin
      frame_q <= frame_i;
    end
    if (state_q == mdio_mgmt_pkg::ST_LOAD) begin
      sreg <= {{PRE_BITS{1'b1}}, frame_q};
    end else if (state_q == mdio_mgmt_pkg::ST_SHIFT && tick) begin
      sreg <= {sreg[`MDIO_FRAME_BITS-2:0], 1'b1};
      // The sample at each tick belongs to the bit period that just ended,
      // so the last 16 samples are the data bits.
      if (rd_op && bit_cnt > RD_AT) begin
        cap <= {cap[14:0], mdio_i};
      end
    end
  end

  assign pins_o = '{mdc: mdc_q, mdo: mdo_q, oe: oe_q};

endmodule

`default_nettype wire

/* mdio_link_poller.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mdio_defs.svh"

module mdio_link_poller (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         mdio_i,
  output mdio_mgmt_pkg::mdio_pins_t   pins_o,
  output logic                        bus_req_o,
  input  wire                         bus_gnt_i,
  output mdio_mgmt_pkg::poll_status_t status_o,
  output logic                        link_up_o
);

  localparam int IV = `MDIO_POLL_INTERVAL;
  localparam int IV_W = $clog2(IV);
  localparam logic [IV_W-1:0] IV_LAST = IV_W'(IV - 1);

  // Fixed read of the status register. The data field is never driven.
  localparam mdio_frame_pkg::mdio_frame_t POLL_FRAME = '{
    start: 2'b01,
    op:    mdio_frame_pkg::MDIO_OP_READ,
    phyad: `MDIO_POLL_PHYAD,
    regad: `MDIO_POLL_REGAD,
    ta:    2'b11,
    data:  16'hffff
  };

  logic [IV_W-1:0] iv_cnt;
  logic            poll_due;
  logic            poll_start;
  logic            busy;
  logic [15:0]     rdata;
  logic            rd_done;
  logic            rd_done_q;

  assign busy       = bus_req_o | ~rd_done;
  assign poll_start = poll_due & ~busy; // A late poll waits for the one in flight.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      iv_cnt    <= '0;
      poll_due  <= 1'b0;
      rd_done_q <= 1'b1;
      status_o  <= '0;
    end else begin
      rd_done_q <= rd_done;
      if (iv_cnt == IV_LAST) begin
        iv_cnt <= '0;
      end else begin
        iv_cnt <= iv_cnt + 1'b1;
      end
      if (poll_start) begin
        poll_due <= 1'b0;
      end
      if (iv_cnt == IV_LAST) begin
        poll_due <= 1'b1;
      end
      if (rd_done && !rd_done_q) begin
        status_o.link_up <= rdata[`MDIO_LINK_BIT];
        status_o.status  <= rdata;
        status_o.count   <= status_o.count + 8'd1;
      end
    end
  end

  assign link_up_o = status_o.link_up;

  mdio_shifter poll_shifter_inst (
    .clk       (clk),
    .rst       (rst),
    .en_i      (poll_start),
    .frame_i   (POLL_FRAME),
    .mdio_i    (mdio_i),
    .pins_o    (pins_o),
    .rdata_o   (rdata),
    .rd_done_o (rd_done),
    .wr_done_o (),
    .bus_req_o (bus_req_o),
    .bus_gnt_i (bus_gnt_i)
  );

endmodule

`default_nettype wire

/* mdio_bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mdio_bus_arbiter (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            host_req_i,
  input  wire                            poll_req_i,
  input  wire mdio_mgmt_pkg::mdio_pins_t host_pins_i,
  input  wire mdio_mgmt_pkg::mdio_pins_t poll_pins_i,
  output logic                           host_gnt_o,
  output logic                           poll_gnt_o,
  output logic                           mdc_o,
  output logic                           mdio_o,
  output logic                           mdio_oe_o
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_HOST,
    OWN_POLL
  } owner_e;

  owner_e owner_q, owner_d;

  always_comb begin
    owner_d = owner_q;
    case (owner_q)
      OWN_NONE: begin
        if (host_req_i) begin
          owner_d = OWN_HOST; // Host wins a tie.
        end else if (poll_req_i) begin
          owner_d = OWN_POLL;
        end
      end
      OWN_HOST: begin
        if (!host_req_i) begin
          owner_d = OWN_NONE;
        end
      end
      OWN_POLL: begin
        if (!poll_req_i) begin
          owner_d = OWN_NONE;
        end
      end
      default: owner_d = OWN_NONE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      owner_q <= OWN_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  assign host_gnt_o = (owner_q == OWN_HOST);
  assign poll_gnt_o = (owner_q == OWN_POLL);

  // Pins fall back to MDC low and released data when nobody owns the bus.
  always_comb begin
    mdc_o     = 1'b0;
    mdio_o    = 1'b0;
    mdio_oe_o = 1'b0;
    if (owner_q == OWN_HOST) begin
      {mdc_o, mdio_o, mdio_oe_o} = {host_pins_i.mdc, host_pins_i.mdo, host_pins_i.oe};
    end else if (owner_q == OWN_POLL) begin
      {mdc_o, mdio_o, mdio_oe_o} = {poll_pins_i.mdc, poll_pins_i.mdo, poll_pins_i.oe};
    end
  end

endmodule

`default_nettype wire

/* mdio_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module mdio_subsys (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              cmd_en_i,
  input  wire mdio_frame_pkg::mdio_frame_t cmd_frame_i,
  output logic [15:0]                      rdata_o,
  output logic                             rd_done_o,
  output logic                             wr_done_o,
  input  wire                              mdio_i,
  output logic                             mdc_o,
  output logic                             mdio_o,
  output logic                             mdio_oe_o,
  output logic                             link_up_o,
  output mdio_mgmt_pkg::poll_status_t      poll_status_o
);

  mdio_mgmt_pkg::mdio_pins_t host_pins;
  mdio_mgmt_pkg::mdio_pins_t poll_pins;
  logic                      host_req;
  logic                      poll_req;
  logic                      host_gnt;
  logic                      poll_gnt;

  mdio_shifter host_shifter_inst (
    .clk       (clk),
    .rst       (rst),
    .en_i      (cmd_en_i),
    .frame_i   (cmd_frame_i),
    .mdio_i    (mdio_i),
    .pins_o    (host_pins),
    .rdata_o   (rdata_o),
    .rd_done_o (rd_done_o),
    .wr_done_o (wr_done_o),
    .bus_req_o (host_req),
    .bus_gnt_i (host_gnt)
  );

  mdio_link_poller link_poller_inst (
    .clk       (clk),
    .rst       (rst),
    .mdio_i    (mdio_i),
    .pins_o    (poll_pins),
    .bus_req_o (poll_req),
    .bus_gnt_i (poll_gnt),
    .status_o  (poll_status_o),
    .link_up_o (link_up_o)
  );

  mdio_bus_arbiter bus_arbiter_inst (
    .clk         (clk),
    .rst         (rst),
    .host_req_i  (host_req),
    .poll_req_i  (poll_req),
    .host_pins_i (host_pins),
    .poll_pins_i (poll_pins),
    .host_gnt_o  (host_gnt),
    .poll_gnt_o  (poll_gnt),
    .mdc_o       (mdc_o),
    .mdio_o      (mdio_o),
    .mdio_oe_o   (mdio_oe_o)
  );

endmodule

`default_nettype wire

/* mdio_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mdio_defs.svh"

module mdio_checker (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              cmd_en_i,
  input  wire mdio_frame_pkg::mdio_frame_t cmd_frame_i,
  input  wire [15:0]                       rdata_i,
  input  wire                              rd_done_i,
  input  wire                              wr_done_i,
  input  wire                              mdc_i,
  input  wire                              mdio_i,
  input  wire                              mdio_oe_i,
  input  wire                              link_up_i,
  input  wire mdio_mgmt_pkg::poll_status_t poll_status_i,
  output logic [31:0]                      err_cnt_o,
  output logic [31:0]                      chk_cnt_o
);

  localparam int TAIL_BITS = `MDIO_FRAME_BITS - `MDIO_RD_SAMPLE;

  mdio_frame_pkg::mdio_frame_t host_q[$];
  mdio_frame_pkg::mdio_frame_t cmd_hold;
  logic [15:0] rd_exp_q[$];
  logic [15:0] poll_exp_q[$];
  logic [15:0] mirror [32];
  logic [63:0] sr;
  logic [63:0] host_exp;
  logic [63:0] poll_exp;
  logic [31:0] cmd_cnt;
  logic [31:0] cmd_taken;
  logic [7:0]  cnt_q;
  int          nbits;
  int          rd_left;
  int          wr_pend;
  int          errs;
  int          checks;
  logic        mdc_q;
  logic        rd_q;
  logic        wr_q;
  logic        reset_checked;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [15:0] fill_value(input logic [4:0] addr);
    return {addr, 6'h2a, addr}; // Same power-up contents as the PHY model.
  endfunction

  // Pin sequence of a whole transaction with the first bit at the MSB.
  function automatic logic [63:0] expected_pins(input mdio_frame_pkg::mdio_frame_t f);
    return {32'hffff_ffff, f};
  endfunction

  function automatic logic [15:0] expected_read(input logic [4:0] regad);
    return mirror[regad];
  endfunction

  function automatic mdio_frame_pkg::mdio_frame_t poll_frame();
    mdio_frame_pkg::mdio_frame_t f;
    f.start = 2'b01;
    f.op    = mdio_frame_pkg::MDIO_OP_READ;
    f.phyad = `MDIO_POLL_PHYAD;
    f.regad = `MDIO_POLL_REGAD;
    f.ta    = 2'b11;
    f.data  = 16'hffff;
    return f;
  endfunction

  task automatic compare(input string sig, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errs++;
      $display("ERROR t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
    end
  endtask

  initial begin
    for (int i = 0; i < 32; i++) begin
      mirror[i] = fill_value(5'(i));
    end
    errs          = 0;
    checks        = 0;
    reset_checked = 1'b0;
    cmd_taken     = '0;
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      cmd_cnt <= '0;
    end else if (cmd_en_i) begin
      cmd_hold <= cmd_frame_i; // The testbench strobes only while the host is idle.
      cmd_cnt  <= cmd_cnt + 1;
    end
  end

  ////////////////////
  // Comparison
  ////////////////////

  always @(negedge clk) begin
    if (rst) begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        compare("rd_done_o", 1, rd_done_i);
        compare("wr_done_o", 1, wr_done_i);
        compare("mdio_oe_o", 0, mdio_oe_i);
        compare("mdc_o", 0, mdc_i);
        compare("link_up_o", 0, link_up_i);
        compare("poll_status_o", 0, poll_status_i);
      end
      nbits   = 0;
      rd_left = 0;
      wr_pend = 0;
      mdc_q   = 1'b0;
      rd_q    = 1'b1;
      wr_q    = 1'b1;
      cnt_q   = '0;
    end else begin
      if (cmd_cnt != cmd_taken) begin
        host_q.push_back(cmd_hold);
        cmd_taken = cmd_cnt;
      end
      if (mdc_i && !mdc_q) begin
        if (rd_left > 0) begin
          compare("mdio_oe_o", 0, mdio_oe_i); // PHY owns turnaround and data.
          rd_left--;
        end else if (mdio_oe_i) begin
          sr = {sr[62:0], mdio_i};
          nbits++;
          if (nbits == `MDIO_RD_SAMPLE && sr[11:10] == 2'b10) begin
            checks++;
            poll_exp = expected_pins(poll_frame());
            if (host_q.size() > 0) begin
              host_exp = expected_pins(host_q[0]);
            end else begin
              host_exp = poll_exp;
            end
            if (host_q.size() > 0 && sr[45:0] == host_exp[63:TAIL_BITS]) begin
              rd_exp_q.push_back(expected_read(host_q[0].regad));
              void'(host_q.pop_front());
            end else if (sr[45:0] == poll_exp[63:TAIL_BITS]) begin
              poll_exp_q.push_back(expected_read(`MDIO_POLL_REGAD));
            end else begin
              errs++;
              $display("ERROR t=%0t mdio_o read frame expected %0h actual %0h", $time,
                       host_exp[63:TAIL_BITS], sr[45:0]);
            end
            nbits   = 0;
            rd_left = TAIL_BITS;
          end else if (nbits == `MDIO_FRAME_BITS) begin
            if (host_q.size() > 0) begin
              compare("mdio_o write frame", expected_pins(host_q[0]), sr);
              mirror[host_q[0].regad] = host_q[0].data;
              void'(host_q.pop_front());
              wr_pend++;
            end else begin
              errs++;
              $display("ERROR t=%0t a write frame appeared with no host command pending",
                       $time);
            end
            nbits = 0;
          end
        end
      end
      mdc_q = mdc_i;
      if (rd_done_i && !rd_q) begin
        if (rd_exp_q.size() == 0) begin
          errs++;
          $display("ERROR t=%0t rd_done_o rose without a decoded host read", $time);
        end else begin
          compare("rdata_o", rd_exp_q.pop_front(), rdata_i);
        end
      end
      rd_q = rd_done_i;
      if (wr_done_i && !wr_q) begin
        if (wr_pend == 0) begin
          errs++;
          $display("ERROR t=%0t wr_done_o rose without a decoded host write", $time);
        end else begin
          checks++;
          wr_pend--;
        end
      end
      wr_q = wr_done_i;
      if (poll_status_i.count != cnt_q) begin
        if (poll_exp_q.size() == 0) begin
          errs++;
          $display("ERROR t=%0t poll count moved without a decoded poll frame", $time);
        end else begin
          compare("poll_status_o.status", poll_exp_q[0], poll_status_i.status);
          compare("link_up_o", poll_exp_q[0][`MDIO_LINK_BIT], link_up_i);
          void'(poll_exp_q.pop_front());
        end
      end
      cnt_q = poll_status_i.count;
    end
  end

  assign err_cnt_o = errs;
  assign chk_cnt_o = checks;

endmodule

`default_nettype wire

/* mdio_subsys_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mdio_subsys_tb;

  localparam int WAIT_LIMIT = 20000;

  logic                        clk;
  logic                        rst;
  logic                        cmd_en;
  mdio_frame_pkg::mdio_frame_t cmd_frame;
  logic [15:0]                 rdata;
  logic                        rd_done;
  logic                        wr_done;
  logic                        mdio_i;
  logic                        mdc;
  logic                        mdio_o;
  logic                        mdio_oe;
  logic                        link_up;
  mdio_mgmt_pkg::poll_status_t poll_status;
  logic [31:0]                 err_cnt;
  logic [31:0]                 chk_cnt;
  logic [31:0]                 rng;

  // PHY register model.
  logic [15:0] phy_mem [32];
  logic        phy_out;
  logic [12:0] phy_hdr;
  logic [17:0] phy_wr;
  logic [15:0] phy_word;
  logic [4:0]  phy_reg;
  int          phy_mode;
  int          phy_ones;
  int          phy_cnt;
  int          phy_skip;
  int          phy_left;

  mdio_subsys mdio_subsys_inst (
    .clk           (clk),
    .rst           (rst),
    .cmd_en_i      (cmd_en),
    .cmd_frame_i   (cmd_frame),
    .rdata_o       (rdata),
    .rd_done_o     (rd_done),
    .wr_done_o     (wr_done),
    .mdio_i        (mdio_i),
    .mdc_o         (mdc),
    .mdio_o        (mdio_o),
    .mdio_oe_o     (mdio_oe),
    .link_up_o     (link_up),
    .poll_status_o (poll_status)
  );

  mdio_checker checker_inst (
    .clk           (clk),
    .rst           (rst),
    .cmd_en_i      (cmd_en),
    .cmd_frame_i   (cmd_frame),
    .rdata_i       (rdata),
    .rd_done_i     (rd_done),
    .wr_done_i     (wr_done),
    .mdc_i         (mdc),
    .mdio_i        (mdio_o),
    .mdio_oe_i     (mdio_oe),
    .link_up_i     (link_up),
    .poll_status_i (poll_status),
    .err_cnt_o     (err_cnt),
    .chk_cnt_o     (chk_cnt)
  );

  assign mdio_i = mdio_oe ? mdio_o : phy_out; // Pull-up idles the line high.

  ////////////////////
  // PHY model
  ////////////////////

  always @(posedge mdc) begin
    if (mdio_oe) begin
      case (phy_mode)
        0: begin
          if (mdio_o) begin
            phy_ones++;
          end else begin
            if (phy_ones >= 32) begin
              phy_mode = 1; // First start bit seen.
              phy_cnt  = 0;
            end
            phy_ones = 0;
          end
        end
        1: begin
          phy_hdr = {phy_hdr[11:0], mdio_o};
          phy_cnt++;
          if (phy_cnt == 13) begin
            phy_reg = phy_hdr[4:0];
            if (phy_hdr[11:10] == 2'b10) begin
              phy_word = phy_mem[phy_reg];
              phy_skip = 3; // Regad LSB fall and both turnaround falls.
              phy_left = 16;
              phy_mode = 0;
            end else begin
              phy_mode = 2;
              phy_cnt  = 0;
            end
          end
        end
        default: begin
          phy_wr = {phy_wr[16:0], mdio_o};
          phy_cnt++;
          if (phy_cnt == 18) begin
            phy_mem[phy_reg] = phy_wr[15:0];
            phy_mode         = 0;
          end
        end
      endcase
    end
  end

  always @(negedge mdc) begin
    if (phy_left > 0) begin
      if (phy_skip > 0) begin
        phy_skip--;
      end else begin
        phy_out  <= phy_word[15];
        phy_word = {phy_word[14:0], 1'b0};
        phy_left--;
      end
    end else begin
      phy_out <= 1'b1;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic mdio_frame_pkg::mdio_frame_t make_frame(input logic is_write,
                                                             input logic [4:0] regad,
                                                             input logic [15:0] data);
    mdio_frame_pkg::mdio_frame_t f;
    f.start = 2'b01;
    f.phyad = 5'd2; // Poll uses address 1, so host frames stay distinguishable.
    f.regad = regad;
    if (is_write) begin
      f.op   = mdio_frame_pkg::MDIO_OP_WRITE;
      f.ta   = 2'b10;
      f.data = data;
    end else begin
      f.op   = mdio_frame_pkg::MDIO_OP_READ;
      f.ta   = 2'b11;
      f.data = 16'hffff;
    end
    return f;
  endfunction

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s at t=%0t", what, $time);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic wait_host_idle();
    int n;
    for (n = 0; n < WAIT_LIMIT && !(rd_done && wr_done); n++) begin
      @(negedge clk);
    end
    if (!(rd_done && wr_done)) begin
      abort_run("the host done levels to rise");
    end
  endtask

  task automatic host_cmd(input mdio_frame_pkg::mdio_frame_t f);
    int n;
    wait_host_idle();
    @(negedge clk);
    cmd_en    = 1'b1;
    cmd_frame = f;
    @(negedge clk);
    cmd_en = 1'b0;
    for (n = 0; n < WAIT_LIMIT && rd_done && wr_done; n++) begin
      @(negedge clk);
    end
    if (rd_done && wr_done) begin
      abort_run("the host command to start");
    end
    wait_host_idle();
  endtask

  task automatic wait_poll();
    int         n;
    logic [7:0] old;
    old = poll_status.count;
    for (n = 0; n < WAIT_LIMIT && poll_status.count == old; n++) begin
      @(negedge clk);
    end
    if (poll_status.count == old) begin
      abort_run("a completed link poll");
    end
  endtask

  task automatic test_done(input int num, input string name);
    $display("test %0d %s finished, %0d errors so far", num, name, err_cnt);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    int n;
    for (int i = 0; i < 32; i++) begin
      phy_mem[i] = {5'(i), 6'h2a, 5'(i)};
    end
    phy_out   = 1'b1;
    phy_mode  = 0;
    phy_ones  = 0;
    phy_cnt   = 0;
    phy_skip  = 0;
    phy_left  = 0;
    rst       = 1'b1;
    cmd_en    = 1'b0;
    cmd_frame = '0;
    rng       = 32'hddb;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_done(1, "reset");

    host_cmd(make_frame(1'b1, 5'd5, 16'hbeef));
    test_done(2, "host write");

    host_cmd(make_frame(1'b0, 5'd5, 16'h0));
    test_done(3, "host read");

    host_cmd(make_frame(1'b1, 5'd1, phy_mem[1] ^ 16'h0004));
    wait_poll();
    test_done(4, "link poll");

    for (n = 0; n < WAIT_LIMIT && !(mdio_oe && rd_done && wr_done); n++) begin
      @(negedge clk);
    end
    if (!(mdio_oe && rd_done && wr_done)) begin
      abort_run("a poll frame on the bus");
    end
    host_cmd(make_frame(1'b0, 5'd1, 16'h0));
    wait_poll();
    test_done(5, "contention");

    for (int i = 0; i < 24; i++) begin
      rng = xorshift(rng);
      host_cmd(make_frame(rng[8], rng[4:0], rng[31:16]));
    end
    test_done(6, "random traffic");

    repeat (4) @(negedge clk);
    $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mdio_subsys.f */
+incdir+.
mdio_frame_pkg.sv
mdio_mgmt_pkg.sv
mdio_shifter.sv
mdio_link_poller.sv
mdio_bus_arbiter.sv
mdio_subsys.sv
mdio_checker.sv
mdio_subsys_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = mdio_subsys_tb
FILELIST = mdio_subsys.f
LOG      = sim.log
BIN      = sim_$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(BIN)
	./obj_dir/$(BIN) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
